// ==== rtl/rotq_pkg.sv ====
package rotq_pkg;

    // Queue geometry
    localparam int data_w  = 8;
    localparam int depth   = 8;
    localparam int addr_w  = 3;

    // Occupancy and step values must reach depth itself
    localparam int count_w = 4;

    // Occupancy at which the queue reports full
    localparam logic [count_w-1:0] count_full = count_w'(depth);

    // Step counter reference values
    localparam logic [count_w-1:0] step_none = '0;
    localparam logic [count_w-1:0] step_one  = count_w'(1);

    // Controller states
    typedef enum logic [1:0] {
        st_idle = 2'b00,
        st_spin = 2'b01
    } rotq_state_t;

endpackage

// ==== rtl/rotq_storage.sv ====
module rotq_storage
    import rotq_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push,
    input  logic [data_w-1:0]  push_data,
    input  logic               pop,
    input  logic               recirc,
    output logic [data_w-1:0]  head_data,
    output logic [count_w-1:0] count,
    output logic               full,
    output logic               empty
);

    // Entry array, addressed circularly by the two pointers
    logic [data_w-1:0] mem [depth];

    logic [addr_w-1:0]  wr_ptr;
    logic [addr_w-1:0]  rd_ptr;
    logic [count_w-1:0] occupancy;

    // Qualified operations
    logic do_push;
    logic do_pop;
    logic do_recirc;

    assign full  = (occupancy == count_full);
    assign empty = (occupancy == step_none);
    assign count = occupancy;

    // Head entry, forced to zero when nothing is stored
    assign head_data = empty ? '0 : mem[rd_ptr];

    // Full and empty checks live here, not in the controller
    assign do_recirc = recirc && !empty;
    assign do_push   = push && !full && !do_recirc;
    assign do_pop    = pop && !empty && !do_recirc && !push;

    // Entry writes
    always_ff @(posedge clk) begin
        if (do_recirc) begin
            // Head moves to the tail slot
            mem[wr_ptr] <= mem[rd_ptr];
        end else if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Write pointer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (do_recirc || do_push) begin
            // Wraps naturally at depth
            wr_ptr <= wr_ptr + addr_w'(1);
        end
    end

    // Read pointer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (do_recirc || do_pop) begin
            rd_ptr <= rd_ptr + addr_w'(1);
        end
    end

    // Occupancy, untouched by a recirculation step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupancy <= '0;
        end else if (do_push) begin
            occupancy <= occupancy + step_one;
        end else if (do_pop) begin
            occupancy <= occupancy - step_one;
        end
    end

endmodule

// ==== rtl/rotq_step_counter.sv ====
module rotq_step_counter
    import rotq_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load,
    input  logic [count_w-1:0] load_value,
    output logic               last
);

    // Steps still to run, including the current one
    logic [count_w-1:0] remaining;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remaining <= step_none;
        end else if (load) begin
            remaining <= load_value;
        end else if (remaining != step_none) begin
            remaining <= remaining - step_one;
        end
    end

    // High during the final recirculation cycle
    assign last = (remaining == step_one);

endmodule

// ==== rtl/rotq_ctrl.sv ====
module rotq_ctrl
    import rotq_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  logic               rd_en,
    input  logic               rotate_en,
    input  logic [addr_w-1:0]  rotate_amount,
    input  logic               rotate_right,
    input  logic [count_w-1:0] count,
    input  logic               last,
    output logic               push,
    output logic               pop,
    output logic               recirc,
    output logic               load,
    output logic [count_w-1:0] load_value,
    output logic               busy
);

    rotq_state_t state;
    rotq_state_t state_nxt;

    logic [count_w-1:0] amount_ext;
    logic               req_valid;

    assign amount_ext = count_w'(rotate_amount);

    // Nonzero and below the count, which also rules out an empty queue
    assign req_valid = rotate_en
                    && (amount_ext != step_none)
                    && (amount_ext < count);

    // Right by k equals left by count minus k
    assign load_value = rotate_right ? (count - amount_ext) : amount_ext;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (req_valid) begin
                    state_nxt = st_spin;
                end
            end
            st_spin: begin
                // Last step runs in this cycle
                if (last) begin
                    state_nxt = st_idle;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    assign busy = (state == st_spin);

    // Counter is loaded on the accepting edge
    assign load = (state == st_idle) && req_valid;

    // One head-to-tail move per spin cycle
    assign recirc = busy;

    // User strobes are dropped while spinning; a write wins over a read
    assign push = wr_en && !busy;
    assign pop  = rd_en && !busy && !push;

endmodule

// ==== rtl/rotq_top.sv ====
module rotq_top
    import rotq_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  logic [data_w-1:0]  wr_data,
    output logic               full,
    input  logic               rd_en,
    output logic [data_w-1:0]  rd_data,
    output logic               empty,
    input  logic               rotate_en,
    input  logic [addr_w-1:0]  rotate_amount,
    input  logic               rotate_right,
    output logic [count_w-1:0] data_count,
    output logic               busy
);

    // Controller to storage
    logic push;
    logic pop;
    logic recirc;

    // Controller and step counter
    logic               load;
    logic [count_w-1:0] load_value;
    logic               last;

    // Occupancy, shared by the controller and the status port
    logic [count_w-1:0] count;

    assign data_count = count;

    rotq_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_en         (wr_en),
        .rd_en         (rd_en),
        .rotate_en     (rotate_en),
        .rotate_amount (rotate_amount),
        .rotate_right  (rotate_right),
        .count         (count),
        .last          (last),
        .push          (push),
        .pop           (pop),
        .recirc        (recirc),
        .load          (load),
        .load_value    (load_value),
        .busy          (busy)
    );

    rotq_step_counter u_step_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load),
        .load_value (load_value),
        .last       (last)
    );

    rotq_storage u_storage (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (wr_data),
        .pop       (pop),
        .recirc    (recirc),
        .head_data (rd_data),
        .count     (count),
        .full      (full),
        .empty     (empty)
    );

endmodule

// ==== sim/rotq_properties.sv ====
module rotq_properties
    import rotq_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               full,
    input  logic               empty,
    input  logic               busy,
    input  logic [count_w-1:0] count,
    input  logic [data_w-1:0]  rd_data
);

    timeunit 1ns;
    timeprecision 1ps;

    // Status flags are mutually exclusive
    full_empty_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(full && empty)
    ) else $error("full and empty are high together");

    // No push or pop lands while the queue spins
    count_stable_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        (busy && $past(busy)) |-> $stable(count)
    ) else $error("occupancy changed during a rotation");

    // Head output is forced low on an empty queue
    rd_data_zero_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        empty |-> (rd_data == '0)
    ) else $error("rd_data is nonzero while the queue is empty");

endmodule

// ==== sim/rotq_checker.sv ====
module rotq_checker
    import rotq_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  logic [data_w-1:0]  wr_data,
    input  logic               rd_en,
    input  logic               rotate_en,
    input  logic [addr_w-1:0]  rotate_amount,
    input  logic               rotate_right,
    input  logic [data_w-1:0]  rd_data,
    input  logic [count_w-1:0] data_count,
    input  logic               full,
    input  logic               empty,
    input  logic               busy,
    input  logic [7:0]         test_id,
    input  logic               test_end,
    output int                 tests_passed,
    output int                 tests_failed,
    output int                 error_total
);

    timeunit 1ns;
    timeprecision 1ps;

    // Reference queue, head at index 0
    logic [data_w-1:0] model_q [$];

    // Busy cycles still expected from the last accepted rotation
    int spin_left;
    int errors_at_start;
    bit checking;

    // Accepted only for amounts from 1 to count minus 1
    function automatic void rotate_model(int amount, bit right);
        logic [data_w-1:0] rotated [$];
        int n;
        int start;
        n = model_q.size();
        if (amount > 0 && amount < n) begin
            // New head is old entry k for left, n - k for right
            start = right ? n - amount : amount;
            for (int i = 0; i < n; i++) begin
                rotated.push_back(model_q[(start + i) % n]);
            end
            model_q = rotated;
            // One head-to-tail move per step, so steps equal the new head index
            spin_left = start;
        end
    endfunction

    function automatic int head_value();
        if (model_q.size() == 0) begin
            return 0;
        end
        return int'(model_q[0]);
    endfunction

    task automatic check_field(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("** Error: time %0d ns: test %0d: %s is %0h, expected %0h",
                     $time, test_id, what, actual, expected);
            error_total++;
        end
    endtask

    task automatic report_test();
        int errors;
        errors = error_total - errors_at_start;
        errors_at_start = error_total;
        if (errors == 0) begin
            $display("Test %0d passed", test_id);
            tests_passed++;
        end else begin
            $display("Test %0d failed with %0d errors", test_id, errors);
            tests_failed++;
        end
    endtask

    // Model update from the strobes seen at the rising edge
    always @(posedge clk) begin
        if (!rst_n) begin
            model_q.delete();
            spin_left = 0;
            checking  = 1'b0;
        end else begin
            checking = 1'b1;
            if (spin_left > 0) begin
                // User strobes and new requests are dropped while spinning
                spin_left--;
            end else if (wr_en) begin
                if (model_q.size() < depth) begin
                    model_q.push_back(wr_data);
                end
            end else if (rd_en) begin
                if (model_q.size() > 0) begin
                    model_q.delete(0);
                end
            end else if (rotate_en) begin
                rotate_model(int'(rotate_amount), rotate_right);
            end
            if (test_end) begin
                report_test();
            end
        end
    end

    // Outputs are settled mid-cycle
    always @(negedge clk) begin
        if (checking) begin
            check_field("busy", int'(spin_left > 0), int'(busy));
            check_field("data_count", model_q.size(), int'(data_count));
            check_field("full", int'(model_q.size() == depth), int'(full));
            check_field("empty", int'(model_q.size() == 0), int'(empty));
            // Head order only settles once the spin is over
            if (spin_left == 0) begin
                check_field("rd_data", head_value(), int'(rd_data));
            end
        end
    end

endmodule

// ==== sim/rotq_tb.sv ====
module rotq_tb
    import rotq_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_rows     = 28;
    localparam int busy_limit = 40;

    localparam logic [2:0] op_idle   = 3'd0;
    localparam logic [2:0] op_write  = 3'd1;
    localparam logic [2:0] op_read   = 3'd2;
    localparam logic [2:0] op_rotate = 3'd3;
    // Rotate, then one write and one read while busy
    localparam logic [2:0] op_poke   = 3'd4;

    typedef struct packed {
        logic [7:0]        test;
        logic [2:0]        op;
        logic [3:0]        reps;
        logic              rnd;
        logic [data_w-1:0] data;
        logic [addr_w-1:0] amount;
        logic              right;
    } row_t;

    logic               clk;
    logic               rst_n;
    logic               wr_en;
    logic [data_w-1:0]  wr_data;
    logic               full;
    logic               rd_en;
    logic [data_w-1:0]  rd_data;
    logic               empty;
    logic               rotate_en;
    logic [addr_w-1:0]  rotate_amount;
    logic               rotate_right;
    logic [count_w-1:0] data_count;
    logic               busy;

    logic [7:0] test_id;
    logic       test_end;

    int tests_passed;
    int tests_failed;
    int error_total;
    int timeouts;
    int seed;

    row_t rows [n_rows];

    initial clk = 1'b0;
    always #10 clk = ~clk;

    rotq_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_en         (wr_en),
        .wr_data       (wr_data),
        .full          (full),
        .rd_en         (rd_en),
        .rd_data       (rd_data),
        .empty         (empty),
        .rotate_en     (rotate_en),
        .rotate_amount (rotate_amount),
        .rotate_right  (rotate_right),
        .data_count    (data_count),
        .busy          (busy)
    );

    rotq_checker u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_en         (wr_en),
        .wr_data       (wr_data),
        .rd_en         (rd_en),
        .rotate_en     (rotate_en),
        .rotate_amount (rotate_amount),
        .rotate_right  (rotate_right),
        .rd_data       (rd_data),
        .data_count    (data_count),
        .full          (full),
        .empty         (empty),
        .busy          (busy),
        .test_id       (test_id),
        .test_end      (test_end),
        .tests_passed  (tests_passed),
        .tests_failed  (tests_failed),
        .error_total   (error_total)
    );

    bind rotq_top rotq_properties u_props (
        .clk     (clk),
        .rst_n   (rst_n),
        .full    (full),
        .empty   (empty),
        .busy    (busy),
        .count   (count),
        .rd_data (rd_data)
    );

    function automatic row_t make_row(int test, logic [2:0] op, int reps, int rnd,
                                      int data, int amount, int right);
        row_t r;
        r.test   = 8'(test);
        r.op     = op;
        r.reps   = 4'(reps);
        r.rnd    = (rnd != 0);
        r.data   = data_w'(data);
        r.amount = addr_w'(amount);
        r.right  = (right != 0);
        return r;
    endfunction

    // Columns: test, op, repeats, random data, data, amount, right
    task automatic load_table();
        rows[0]  = make_row(1, op_idle,   2, 0, 0,     0, 0);
        // Fill, overflow, drain, then read while empty
        rows[1]  = make_row(2, op_write,  8, 1, 0,     0, 0);
        rows[2]  = make_row(2, op_write,  1, 0, 'hee,  0, 0);
        rows[3]  = make_row(2, op_read,   8, 0, 0,     0, 0);
        rows[4]  = make_row(2, op_read,   1, 0, 0,     0, 0);
        rows[5]  = make_row(3, op_write,  5, 1, 0,     0, 0);
        rows[6]  = make_row(3, op_rotate, 1, 0, 0,     2, 0);
        rows[7]  = make_row(3, op_read,   5, 0, 0,     0, 0);
        rows[8]  = make_row(3, op_write,  7, 1, 0,     0, 0);
        rows[9]  = make_row(3, op_rotate, 1, 0, 0,     6, 0);
        rows[10] = make_row(3, op_read,   7, 0, 0,     0, 0);
        rows[11] = make_row(4, op_write,  7, 1, 0,     0, 0);
        rows[12] = make_row(4, op_rotate, 1, 0, 0,     3, 1);
        rows[13] = make_row(4, op_read,   7, 0, 0,     0, 0);
        rows[14] = make_row(4, op_write,  8, 1, 0,     0, 0);
        rows[15] = make_row(4, op_rotate, 1, 0, 0,     1, 1);
        rows[16] = make_row(4, op_read,   8, 0, 0,     0, 0);
        // Empty queue, zero amount, amount at and above the count
        rows[17] = make_row(5, op_rotate, 1, 0, 0,     3, 0);
        rows[18] = make_row(5, op_write,  4, 1, 0,     0, 0);
        rows[19] = make_row(5, op_rotate, 1, 0, 0,     0, 0);
        rows[20] = make_row(5, op_rotate, 1, 0, 0,     4, 1);
        rows[21] = make_row(5, op_rotate, 1, 0, 0,     7, 0);
        rows[22] = make_row(5, op_read,   4, 0, 0,     0, 0);
        rows[23] = make_row(6, op_write,  6, 1, 0,     0, 0);
        rows[24] = make_row(6, op_poke,   1, 0, 0,     3, 0);
        rows[25] = make_row(6, op_poke,   1, 0, 0,     1, 1);
        rows[26] = make_row(6, op_read,   6, 0, 0,     0, 0);
        rows[27] = make_row(6, op_read,   1, 0, 0,     0, 0);
    endtask

    task automatic poke_while_busy();
        wr_en   = 1'b1;
        wr_data = data_w'($random(seed));
        @(negedge clk);
        wr_en = 1'b0;
        rd_en = 1'b1;
        @(negedge clk);
        rd_en = 1'b0;
    endtask

    task automatic wait_not_busy(input logic [7:0] test);
        int cycles;
        cycles = 0;
        while (busy && cycles < busy_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            $display("Test %0d: rotation still running after %0d cycles, giving up on it",
                     test, busy_limit);
            timeouts++;
        end
    endtask

    task automatic apply_row(input row_t r);
        case (r.op)
            op_write: begin
                repeat (r.reps) begin
                    wr_en   = 1'b1;
                    wr_data = r.rnd ? data_w'($random(seed)) : r.data;
                    @(negedge clk);
                end
                wr_en = 1'b0;
            end
            op_read: begin
                repeat (r.reps) begin
                    rd_en = 1'b1;
                    @(negedge clk);
                end
                rd_en = 1'b0;
            end
            op_rotate, op_poke: begin
                rotate_en     = 1'b1;
                rotate_amount = r.amount;
                rotate_right  = r.right;
                @(negedge clk);
                rotate_en = 1'b0;
                if (r.op == op_poke) begin
                    poke_while_busy();
                end
                wait_not_busy(r.test);
            end
            default: begin
                repeat (r.reps) @(negedge clk);
            end
        endcase
    endtask

    // Checker reports the test on the next rising edge
    task automatic finish_test();
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    initial begin
        seed          = 89901;
        timeouts      = 0;
        rst_n         = 1'b0;
        wr_en         = 1'b0;
        wr_data       = '0;
        rd_en         = 1'b0;
        rotate_en     = 1'b0;
        rotate_amount = '0;
        rotate_right  = 1'b0;
        test_id       = '0;
        test_end      = 1'b0;
        load_table();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            test_id = rows[i].test;
            apply_row(rows[i]);
            if (i == n_rows - 1) begin
                finish_test();
            end else if (rows[i + 1].test != rows[i].test) begin
                finish_test();
            end
        end
        // Last falling-edge compare settles before the totals are read
        @(posedge clk);
        $display("Summary: %0d tests passed, %0d tests failed, %0d errors, %0d timeouts",
                 tests_passed, tests_failed, error_total, timeouts);
        if (tests_failed == 0 && error_total == 0 && timeouts == 0 && tests_passed > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/rotq_pkg.sv
rtl/rotq_storage.sv
rtl/rotq_step_counter.sv
rtl/rotq_ctrl.sv
rtl/rotq_top.sv
sim/rotq_properties.sv
sim/rotq_checker.sv
sim/rotq_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the rotating queue testbench with Verilator, run it and judge the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module rotq_tb -f flist.f -o rotq_sim \
    && ./obj_dir/rotq_sim > sim.log 2>&1

test -f sim.log && cat sim.log

grep -q "Something failed" sim.log 2>/dev/null && echo "Simulation failed" && exit 1
grep -q "Everything OK" sim.log 2>/dev/null || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
exit 0
